//--- dv/fetch_unit_checker.sv
// Bound assertions on fetch bus requests and the fetch-to-execute register
module fetch_unit_checker
    import rv32i_types_pkg::*;
    import fetch_pipe_pkg::*;
(
    input logic      CLK,
    input logic      nRST,
    input logic      ren,
    input word_t     addr,
    input logic      busy,
    input logic      redirect,
    input word_t     redirect_pc,
    input logic      ex_stall,
    input fetch_ex_t ex_reg
);

    // Redirect still waiting for its first valid output
    logic  redirect_pending;
    word_t redirect_target;

    // Failed assertion count
    int    failures = 0;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            redirect_pending <= 1'b0;
            redirect_target  <= '0;
        end else if (redirect) begin
            redirect_pending <= 1'b1;
            redirect_target  <= redirect_pc;
        end else if (ex_reg.valid) begin
            redirect_pending <= 1'b0;
        end
    end

    // Bus stays quiet in the first cycle out of reset
    ren_low_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> !ren)
        else begin
            $error("ren high in the first cycle after reset");
            failures++;
        end

    // Valid register contents frozen under back-pressure
    reg_holds_on_stall: assert property (@(posedge CLK) disable iff (!nRST)
        (ex_stall && ex_reg.valid) |=> $stable(ex_reg))
        else begin
            $error("fetch-to-execute register changed while stalled");
            failures++;
        end

    // Pending access keeps its address
    addr_stable_while_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (ren && busy && !redirect) |=> $stable(addr))
        else begin
            $error("instruction address changed while memory busy");
            failures++;
        end

    // First valid word after a redirect comes from the target
    redirect_lands_on_target: assert property (@(posedge CLK) disable iff (!nRST)
        (redirect_pending && ex_reg.valid) |-> (ex_reg.pc == redirect_target))
        else begin
            $error("first valid output after redirect has wrong pc");
            failures++;
        end

endmodule

//--- dv/fetch_unit_tb.sv
// Testbench for the fetch unit with a random-latency instruction memory and a step table
module fetch_unit_tb
    import rv32i_types_pkg::*;
();

    localparam int HALF_PERIOD     = 20;
    localparam int RESET_CYCLES    = 10;
    localparam int DRIVE_DELAY     = 2;
    localparam int CYCLES_PER_STEP = 20;
    localparam int MAX_BUBBLES     = 8;
    // Width of all ex_* outputs packed together
    localparam int SNAP_W          = 164;

    // Small program, one word per index of addr[5:2]
    localparam word_t PROG [16] = '{
        32'h00100093, 32'h00208113, 32'h00310193, 32'h00208463,
        32'h00418213, 32'h002081b3, 32'h00520293, 32'h0080006f,
        32'h00628313, 32'h40208233, 32'h00730393, 32'h00209463,
        32'h00838413, 32'h00000013, 32'h00940493, 32'h000080e7
    };

    typedef struct {
        logic  redirect;
        word_t target;
        int    stall;
        logic  train;
        logic  taken;
        word_t train_pc;
        word_t train_target;
        word_t exp_pc;
        logic  exp_mal;
        logic  exp_fault;
        logic  exp_pred;
        word_t exp_pred_addr;
    } step_t;

    logic  CLK;
    logic  nRST;
    word_t imem_addr;
    logic  imem_ren;
    word_t imem_rdata;
    logic  imem_busy;
    logic  imem_error;
    logic  ex_stall;
    logic  redirect;
    word_t redirect_pc;
    logic  train_valid;
    logic  train_taken;
    word_t train_pc;
    word_t train_target;
    logic  ex_valid;
    word_t ex_instr;
    word_t ex_pc;
    word_t ex_pc4;
    logic  ex_mal_insn;
    logic  ex_fault_insn;
    word_t ex_fault_addr;
    logic  ex_prediction;
    word_t ex_predicted_address;

    step_t  steps [$];
    logic   table_ready = 1'b0;
    integer seed;
    int     mem_left;
    word_t  last_addr;

    fetch_unit i_fetch_unit (.*);

    bind fetch_stage fetch_unit_checker i_fetch_unit_checker (
        .CLK         (CLK),
        .nRST        (nRST),
        .ren         (ibus.ren),
        .addr        (ibus.addr),
        .busy        (hazard_if.i_mem_busy),
        .redirect    (hazard_if.redirect),
        .redirect_pc (hazard_if.redirect_pc),
        .ex_stall    (hazard_if.if_ex_stall),
        .ex_reg      (fetch_ex_reg)
    );

    initial CLK = 1'b0;
    always #(HALF_PERIOD) CLK = ~CLK;

    // Upper address bits fold into the immediate field, opcode untouched
    function automatic word_t fetch_word(input word_t a);
        return PROG[a[5:2]] ^ {a[31:20] ^ a[19:8] ^ {4'h0, a[7:0]}, 20'h0};
    endfunction

    // Bus error region 0x800 to 0x83f
    function automatic logic in_error_region(input word_t a);
        return a[31:6] == 26'h20;
    endfunction

    function automatic logic [SNAP_W-1:0] capture_outputs();
        return {ex_valid, ex_instr, ex_pc, ex_pc4, ex_mal_insn, ex_fault_insn,
                ex_fault_addr, ex_prediction, ex_predicted_address};
    endfunction

    // Assertion failures seen by the bound checker
    function automatic int checker_failures();
        return i_fetch_unit.i_fetch_stage.i_fetch_unit_checker.failures;
    endfunction

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "fetch unit test stopped");
    endtask

    task automatic compare(input string name, input logic [SNAP_W-1:0] got,
                           input logic [SNAP_W-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic add_step(input logic rd, input word_t tgt, input int stall,
                            input logic trn, input logic tkn, input word_t tpc,
                            input word_t ttgt, input word_t epc, input logic mal,
                            input logic flt, input logic prd, input word_t paddr);
        step_t s;
        s = '{rd, tgt, stall, trn, tkn, tpc, ttgt, epc, mal, flt, prd, paddr};
        steps.push_back(s);
    endtask

    task automatic load_steps();
        // redir target stall train taken tpc ttarget | ex_pc mal fault pred pred_addr
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   RESET_PC, 0, 0, 0, 32'h0);
        add_step(0, 32'h0,   3, 0, 0, 32'h0,   32'h0,   32'h104,  0, 0, 0, 32'h0);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h108,  0, 0, 0, 32'h0);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h10c,  0, 0, 0, 32'h0);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h110,  0, 0, 0, 32'h0);
        add_step(1, 32'h140, 0, 0, 0, 32'h0,   32'h0,   32'h140,  0, 0, 0, 32'h0);
        add_step(0, 32'h0,   2, 0, 0, 32'h0,   32'h0,   32'h144,  0, 0, 0, 32'h0);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h148,  0, 0, 0, 32'h0);
        add_step(1, 32'h202, 0, 0, 0, 32'h0,   32'h0,   32'h202,  1, 0, 0, 32'h0);
        add_step(1, 32'h800, 0, 0, 0, 32'h0,   32'h0,   32'h800,  0, 1, 0, 32'h0);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h804,  0, 1, 0, 32'h0);
        add_step(1, 32'h10c, 0, 1, 1, 32'h10c, 32'h180, 32'h10c,  0, 0, 1, 32'h180);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h180,  0, 0, 0, 32'h0);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h184,  0, 0, 0, 32'h0);
        add_step(1, 32'h10c, 0, 1, 0, 32'h10c, 32'h0,   32'h10c,  0, 0, 0, 32'h0);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h110,  0, 0, 0, 32'h0);
        add_step(0, 32'h0,   0, 0, 0, 32'h0,   32'h0,   32'h114,  0, 0, 0, 32'h0);
    endtask

    // Instruction memory, 0 to 2 busy cycles per access
    always @(posedge CLK) begin
        #(DRIVE_DELAY);
        if (!imem_ren) begin
            mem_left = 0;
        end else if (!imem_busy || imem_addr != last_addr) begin
            mem_left = $unsigned($random(seed)) % 3;
        end else begin
            mem_left = mem_left - 1;
        end
        last_addr  = imem_addr;
        imem_busy  = imem_ren && (mem_left != 0);
        imem_rdata = fetch_word(imem_addr);
        imem_error = imem_ren && in_error_region(imem_addr);
    end

    // Stop on the first checker assertion failure
    always @(posedge CLK) begin
        if (checker_failures() != 0) begin
            $display("Bound checker assertion failed at %0t", $time);
            fail_run();
        end
    end

    initial begin
        longint limit;
        wait (table_ready);
        limit = (RESET_CYCLES + CYCLES_PER_STEP * steps.size()) * 2 * HALF_PERIOD;
        #(limit);
        $display("Watchdog expired before all steps finished");
        fail_run();
    end

    initial begin
        step_t             s;
        logic [SNAP_W-1:0] snap;
        word_t             exp_instr;
        word_t             exp_next;
        int                bubbles;
        seed         = 87;
        nRST         = 1'b0;
        imem_rdata   = '0;
        imem_busy    = 1'b0;
        imem_error   = 1'b0;
        ex_stall     = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        train_valid  = 1'b0;
        train_taken  = 1'b0;
        train_pc     = '0;
        train_target = '0;
        mem_left     = 0;
        last_addr    = '0;
        load_steps();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #(DRIVE_DELAY);
        nRST = 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            // Redirect and training last one cycle
            redirect     = s.redirect;
            redirect_pc  = s.target;
            train_valid  = s.train;
            train_taken  = s.taken;
            train_pc     = s.train_pc;
            train_target = s.train_target;
            @(posedge CLK);
            #(DRIVE_DELAY);
            redirect    = 1'b0;
            train_valid = 1'b0;
            bubbles     = 0;
            while (!ex_valid) begin
                bubbles++;
                if (bubbles > MAX_BUBBLES) begin
                    $display("No valid fetch output for step %0d after %0d bubbles", i, bubbles);
                    fail_run();
                end
                @(posedge CLK);
                #(DRIVE_DELAY);
            end
            exp_instr = (s.exp_mal || s.exp_fault) ? '0 : fetch_word(s.exp_pc);
            compare("ex_pc", ex_pc, s.exp_pc);
            compare("ex_pc4", ex_pc4, s.exp_pc + 32'd4);
            compare("ex_instr", ex_instr, exp_instr);
            compare("ex_mal_insn", ex_mal_insn, s.exp_mal);
            compare("ex_fault_insn", ex_fault_insn, s.exp_fault);
            if (s.exp_mal || s.exp_fault) begin
                compare("ex_fault_addr", ex_fault_addr, s.exp_pc);
            end
            compare("ex_prediction", ex_prediction, s.exp_pred);
            if (s.exp_pred) begin
                compare("ex_predicted_address", ex_predicted_address, s.exp_pred_addr);
            end
            // Bus already requests the predicted target or the next word
            exp_next = s.exp_pred ? s.exp_pred_addr : s.exp_pc + 32'd4;
            compare("imem_ren", imem_ren, 1'b1);
            compare("imem_addr", imem_addr, exp_next);
            // Everything frozen under back-pressure
            if (s.stall > 0) begin
                snap     = capture_outputs();
                ex_stall = 1'b1;
                repeat (s.stall) begin
                    @(posedge CLK);
                    #(DRIVE_DELAY);
                    compare("ex_* under stall", capture_outputs(), snap);
                end
                ex_stall = 1'b0;
            end
        end
        if (checker_failures() != 0) begin
            $display("Bound checker reported %0d assertion failures", checker_failures());
            fail_run();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

//--- sources.f
verilog/rv32i_types_pkg.sv
verilog/fetch_pipe_pkg.sv
verilog/generic_bus_if.sv
verilog/fetch_hazard_if.sv
verilog/predictor_if.sv
verilog/fetch_hazard_unit.sv
verilog/branch_predictor.sv
verilog/fetch_stage.sv
verilog/fetch_unit.sv
dv/fetch_unit_checker.sv
dv/fetch_unit_tb.sv

//--- verilog/branch_predictor.sv
// Direct-mapped branch target buffer with combinational lookup and edge-triggered training
module branch_predictor
    import rv32i_types_pkg::*;
    import fetch_pipe_pkg::*;
(
    input  logic        CLK,
    input  logic        nRST,
    predictor_if.btb    predict_if
);

    // Table state
    logic [BTB_ENTRIES-1:0] valid_q;
    logic [BTB_TAG_W-1:0]   tag_mem    [BTB_ENTRIES];
    word_t                  target_mem [BTB_ENTRIES];

    // Lookup fields
    logic [BTB_IDX_W-1:0]   rd_idx;
    logic [BTB_TAG_W-1:0]   rd_tag;
    logic                   hit;

    // Training fields
    logic [BTB_IDX_W-1:0]   wr_idx;
    logic [BTB_TAG_W-1:0]   wr_tag;

    // Index from word address bits, tag from the rest
    assign rd_idx = predict_if.current_pc[BTB_IDX_W+1:2];
    assign rd_tag = predict_if.current_pc[31 -: BTB_TAG_W];
    assign wr_idx = predict_if.train_pc[BTB_IDX_W+1:2];
    assign wr_tag = predict_if.train_pc[31 -: BTB_TAG_W];

    // Valid bits
    // Taken training allocates, not-taken training invalidates
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (predict_if.train_valid) begin
            valid_q[wr_idx] <= predict_if.train_taken;
        end
    end

    // Tag and target arrays
    always_ff @(posedge CLK) begin
        if (predict_if.train_valid && predict_if.train_taken) begin
            tag_mem[wr_idx]    <= wr_tag;
            target_mem[wr_idx] <= predict_if.train_target;
        end
    end

    assign hit = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);

    // Only control-flow instructions may redirect
    assign predict_if.predict_taken = hit && (predict_if.is_branch || predict_if.is_jump);
    assign predict_if.target_addr   = target_mem[rd_idx];

endmodule

//--- verilog/fetch_hazard_if.sv
// Control signals between the fetch hazard unit and the fetch stage
interface fetch_hazard_if
    import rv32i_types_pkg::*;
();

    // Downstream requests
    logic  ex_stall;
    logic  redirect;
    word_t redirect_pc;

    // Bus busy as seen by fetch, dropped on a fault
    logic  i_mem_busy;

    // Fetch controls
    logic  pc_en;
    logic  if_ex_flush;
    logic  if_ex_stall;
    logic  iren;

    modport unit (
        input  i_mem_busy,
        output ex_stall, redirect, redirect_pc,
        output pc_en, if_ex_flush, if_ex_stall, iren
    );

    modport fetch (
        output i_mem_busy,
        input  ex_stall, redirect, redirect_pc,
        input  pc_en, if_ex_flush, if_ex_stall, iren
    );

endinterface

//--- verilog/fetch_hazard_unit.sv
// Fetch hazard unit folding stalls, redirects and bus busy into the fetch controls
module fetch_hazard_unit
    import rv32i_types_pkg::*;
(
    input  logic          CLK,
    input  logic          nRST,
    fetch_hazard_if.unit  hazard_if,
    input  logic          ex_stall,
    input  logic          redirect,
    input  word_t         redirect_pc
);

    // Low for the first cycle out of reset
    logic iren_q;

    // Current access finished this cycle
    logic fetch_done;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            iren_q <= 1'b0;
        end else begin
            iren_q <= 1'b1;
        end
    end

    assign hazard_if.iren = iren_q;

    // Pass the downstream requests on to fetch
    assign hazard_if.ex_stall    = ex_stall;
    assign hazard_if.redirect    = redirect;
    assign hazard_if.redirect_pc = redirect_pc;

    // No access is made while iren is low, so nothing completes
    assign fetch_done = iren_q && !hazard_if.i_mem_busy;

    // Redirect always moves the PC
    // Otherwise advance only on a finished, unstalled fetch
    assign hazard_if.pc_en = redirect || (fetch_done && !ex_stall);

    // Bubble into execute on redirect or an unfinished fetch
    assign hazard_if.if_ex_flush = redirect || !fetch_done;

    // Pipeline register holds under back-pressure
    assign hazard_if.if_ex_stall = ex_stall;

endmodule

//--- verilog/fetch_pipe_pkg.sv
// Pipeline-side types for the fetch-to-execute register and the branch target buffer
package fetch_pipe_pkg;
    import rv32i_types_pkg::*;

    // BTB geometry
    // Direct mapped, indexed by PC[5:2]
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = 4;
    // Tag covers PC[31:6]
    localparam int BTB_TAG_W   = 26;

    // Fetch-to-execute register contents
    typedef struct packed {
        logic  valid;
        // Squashed to zero on a fetch exception
        word_t instr;
        word_t pc;
        word_t pc4;
        // Exception flags for the execute stage
        logic  mal_insn;
        logic  fault_insn;
        word_t fault_addr;
        // BTB prediction made at fetch
        logic  prediction;
        word_t predicted_address;
    } fetch_ex_t;

endpackage

//--- verilog/fetch_stage.sv
// Fetch stage with PC register, next-PC select, bus request and fetch-to-execute register
module fetch_stage
    import rv32i_types_pkg::*;
    import fetch_pipe_pkg::*;
(
    input  logic            CLK,
    input  logic            nRST,
    generic_bus_if.cpu      ibus,
    fetch_hazard_if.fetch   hazard_if,
    predictor_if.access     predict_if,
    output fetch_ex_t       fetch_ex_reg
);

    // PC state
    word_t   pc;
    word_t   pc4;
    word_t   npc;

    // Exception detection
    logic    mal_insn;
    logic    fault_insn;
    word_t   fault_addr;

    // Word sent on to execute
    word_t   instr_to_ex;
    sbtype_t instr_sb;

    // PC register and next-PC selection
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= RESET_PC;
        end else if (hazard_if.pc_en) begin
            pc <= npc;
        end
    end

    assign pc4 = pc + 32'd4;

    // Redirect first, then prediction, then sequential
    always_comb begin
        if (hazard_if.redirect) begin
            npc = hazard_if.redirect_pc;
        end else if (predict_if.predict_taken) begin
            npc = predict_if.target_addr;
        end else begin
            npc = pc4;
        end
    end

    // Instruction bus request
    // Address held while pc_en is low, so a stalled fetch re-requests it
    assign ibus.addr = pc;
    assign ibus.ren  = hazard_if.iren;

    // Misaligned PC or bus error
    assign mal_insn   = (pc[1:0] != 2'b00);
    assign fault_insn = ibus.ren && ibus.error;
    assign fault_addr = pc;

    // A fault ends the access without waiting on memory
    assign hazard_if.i_mem_busy = ibus.busy && !(fault_insn || mal_insn);

    // Squash the word on any fetch exception
    assign instr_to_ex = (mal_insn || fault_insn) ? '0 : ibus.rdata;

    // Predictor lookup
    assign instr_sb = sbtype_t'(instr_to_ex);

    assign predict_if.current_pc = pc;
    assign predict_if.is_branch  = (instr_sb.opcode == BRANCH);
    assign predict_if.is_jump    = (instr_sb.opcode == JAL) || (instr_sb.opcode == JALR);

    // Fetch-to-execute register
    // Flush wins unless execute is stalled
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_ex_reg <= '0;
        end else if (hazard_if.if_ex_flush && !hazard_if.if_ex_stall) begin
            fetch_ex_reg <= '0;
        end else if (!hazard_if.if_ex_stall) begin
            // Still valid on exception so execute can trap
            fetch_ex_reg.valid             <= 1'b1;
            fetch_ex_reg.instr             <= instr_to_ex;
            fetch_ex_reg.pc                <= pc;
            fetch_ex_reg.pc4               <= pc4;
            fetch_ex_reg.mal_insn          <= mal_insn;
            fetch_ex_reg.fault_insn        <= fault_insn;
            fetch_ex_reg.fault_addr        <= fault_addr;
            fetch_ex_reg.prediction        <= predict_if.predict_taken;
            fetch_ex_reg.predicted_address <= predict_if.target_addr;
        end
    end

endmodule

//--- verilog/fetch_unit.sv
// Instruction-fetch front end top level with plain instruction bus and execute ports
module fetch_unit
    import rv32i_types_pkg::*;
    import fetch_pipe_pkg::*;
(
    input  logic  CLK,
    input  logic  nRST,
    // Instruction memory
    output word_t imem_addr,
    output logic  imem_ren,
    input  word_t imem_rdata,
    input  logic  imem_busy,
    input  logic  imem_error,
    // Execute feedback
    input  logic  ex_stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    // BTB training
    input  logic  train_valid,
    input  logic  train_taken,
    input  word_t train_pc,
    input  word_t train_target,
    // Fetch-to-execute register
    output logic  ex_valid,
    output word_t ex_instr,
    output word_t ex_pc,
    output word_t ex_pc4,
    output logic  ex_mal_insn,
    output logic  ex_fault_insn,
    output word_t ex_fault_addr,
    output logic  ex_prediction,
    output word_t ex_predicted_address
);

    generic_bus_if  ibus ();
    fetch_hazard_if hazard_if ();
    predictor_if    predict_if ();

    fetch_ex_t fetch_ex_reg;

    // Instruction bus to the pins
    assign imem_addr  = ibus.addr;
    assign imem_ren   = ibus.ren;
    assign ibus.rdata = imem_rdata;
    assign ibus.busy  = imem_busy;
    assign ibus.error = imem_error;

    // Training comes straight from the ports
    assign predict_if.train_valid  = train_valid;
    assign predict_if.train_taken  = train_taken;
    assign predict_if.train_pc     = train_pc;
    assign predict_if.train_target = train_target;

    fetch_hazard_unit i_fetch_hazard_unit (
        .CLK         (CLK),
        .nRST        (nRST),
        .hazard_if   (hazard_if),
        .ex_stall    (ex_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    branch_predictor i_branch_predictor (
        .CLK        (CLK),
        .nRST       (nRST),
        .predict_if (predict_if)
    );

    fetch_stage i_fetch_stage (
        .CLK          (CLK),
        .nRST         (nRST),
        .ibus         (ibus),
        .hazard_if    (hazard_if),
        .predict_if   (predict_if),
        .fetch_ex_reg (fetch_ex_reg)
    );

    // Unpack the register record
    assign ex_valid             = fetch_ex_reg.valid;
    assign ex_instr             = fetch_ex_reg.instr;
    assign ex_pc                = fetch_ex_reg.pc;
    assign ex_pc4               = fetch_ex_reg.pc4;
    assign ex_mal_insn          = fetch_ex_reg.mal_insn;
    assign ex_fault_insn        = fetch_ex_reg.fault_insn;
    assign ex_fault_addr        = fetch_ex_reg.fault_addr;
    assign ex_prediction        = fetch_ex_reg.prediction;
    assign ex_predicted_address = fetch_ex_reg.predicted_address;

endmodule

//--- verilog/generic_bus_if.sv
// Instruction bus between the CPU fetch logic and instruction memory
interface generic_bus_if
    import rv32i_types_pkg::*;
();

    // Request side
    word_t addr;
    logic  ren;

    // Response side
    // rdata and error are valid for addr when busy drops
    word_t rdata;
    logic  busy;
    logic  error;

    modport cpu (
        output addr, ren,
        input  rdata, busy, error
    );

    // A new addr during busy restarts the access
    modport mem (
        input  addr, ren,
        output rdata, busy, error
    );

endinterface

//--- verilog/predictor_if.sv
// Lookup and training signals between the fetch stage and the branch predictor
interface predictor_if
    import rv32i_types_pkg::*;
();

    // Lookup request from fetch
    word_t current_pc;
    logic  is_branch;
    logic  is_jump;

    // Lookup result, combinational
    logic  predict_taken;
    word_t target_addr;

    // Training from branch resolution
    logic  train_valid;
    word_t train_pc;
    word_t train_target;
    logic  train_taken;

    modport access (
        output current_pc, is_branch, is_jump,
        input  predict_taken, target_addr
    );

    modport btb (
        input  current_pc, is_branch, is_jump,
        input  train_valid, train_pc, train_target, train_taken,
        output predict_taken, target_addr
    );

endinterface

//--- verilog/rv32i_types_pkg.sv
// RV32I ISA types shared by the fetch front end and the testbench
package rv32i_types_pkg;

    // Architectural data and address width
    localparam int WORD_W = 32;

    // One architectural word
    typedef logic [WORD_W-1:0] word_t;

    // PC value loaded on reset
    localparam word_t RESET_PC = 32'h00000100;

    // Base opcodes of RV32I
    typedef enum logic [6:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    // B-type layout
    // Immediate bits are scattered across the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_05;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm04_01;
        logic       imm11;
        opcode_t    opcode;
    } sbtype_t;

endpackage
